// ==== vlog.f ====
verilog/mem_stage_pkg.sv
verilog/mem_ctrl.sv
verilog/data_ram.sv
verilog/load_align.sv
verilog/store_merge.sv
verilog/csr_unit.sv
verilog/mem_stage.sv
testbench/tb_mem_stage.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f vlog.f --top-module tb_mem_stage -o sim_tb_mem_stage
./obj_dir/sim_tb_mem_stage > sim.log 2>&1
cat sim.log
if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== testbench/tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage;

    localparam int          RAM_DEPTH = 256;
    localparam int          XLEN      = mem_stage_pkg::XLEN;
    // addi x0, x0, 0 stands in for any non-memory instruction
    localparam logic [31:0] BUBBLE    = 32'h0000_0013;

    logic            clk;
    logic            arst_n_i;
    logic [31:0]     instr;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] ls_res;
    logic [XLEN-1:0] csr_data;
    logic [XLEN-1:0] mtvec;

    // reference model state
    logic [XLEN-1:0] model_mem [RAM_DEPTH];
    logic [XLEN-1:0] model_csr [3];
    logic [31:0]     lfsr_q;
    int              errors;
    int              checks;

    mem_stage #(
        .RAM_DEPTH (RAM_DEPTH)
    ) dut (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .instr_i    (instr),
        .alu_res_i  (alu_res),
        .rs2_i      (rs2),
        .wb_data_i  (wb_data),
        .ls_res_o   (ls_res),
        .csr_data_o (csr_data),
        .mtvec_o    (mtvec)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [XLEN-1:0] take_bits(input int n);
        logic [XLEN-1:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[XLEN-2:0], lfsr_q[0]};
            lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
        end
        return val;
    endfunction

    function automatic logic [31:0] load_op(input logic [2:0] f3, input logic [4:0] rd);
        mem_stage_pkg::instr_u ins;
        ins              = '0;
        ins.itype.opcode = mem_stage_pkg::OPC_LOAD;
        ins.itype.funct3 = f3;
        ins.itype.rd     = rd;
        ins.itype.rs1    = 5'd2;
        return ins;
    endfunction

    function automatic logic [31:0] store_op(input logic [2:0] f3, input logic [4:0] src2);
        mem_stage_pkg::instr_u ins;
        ins              = '0;
        ins.stype.opcode = mem_stage_pkg::OPC_STORE;
        ins.stype.funct3 = f3;
        ins.stype.rs2    = src2;
        ins.stype.rs1    = 5'd2;
        return ins;
    endfunction

    function automatic logic [31:0] csr_op(input logic [2:0] f3, input logic [11:0] addr,
                                           input logic [4:0] src);
        mem_stage_pkg::instr_u ins;
        ins              = '0;
        ins.itype.opcode = mem_stage_pkg::OPC_SYSTEM;
        ins.itype.funct3 = f3;
        ins.itype.imm    = addr;
        ins.itype.rs1    = src;
        ins.itype.rd     = 5'd1;
        return ins;
    endfunction

    // bytes covered by an access of this size
    function automatic logic [XLEN-1:0] lane_mask(input logic [2:0] f3);
        case (f3[1:0])
            2'd0:    return 64'h0000_0000_0000_00ff;
            2'd1:    return 64'h0000_0000_0000_ffff;
            2'd2:    return 64'h0000_0000_ffff_ffff;
            default: return '1;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] load_value(input logic [XLEN-1:0] dw, input int off,
                                                   input logic [2:0] f3);
        logic [XLEN-1:0] v;
        v = (dw >> (8 * off)) & lane_mask(f3);
        if (!f3[2]) begin
            case (f3[1:0])
                2'd0:    v = XLEN'($signed(v[7:0]));
                2'd1:    v = XLEN'($signed(v[15:0]));
                2'd2:    v = XLEN'($signed(v[31:0]));
                default: v = dw;
            endcase
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] dw, input int off,
                                                    input logic [2:0] f3,
                                                    input logic [XLEN-1:0] data);
        logic [XLEN-1:0] m;
        m = lane_mask(f3) << (8 * off);
        return (dw & ~m) | ((data << (8 * off)) & m);
    endfunction

    // one instruction per clock with outputs read late in the cycle
    task automatic run_cycle(input logic [31:0] ins, input logic [XLEN-1:0] alu,
                             input logic [XLEN-1:0] src2, input logic [XLEN-1:0] wb);
        @(posedge clk);
        #2;
        instr   = ins;
        alu_res = alu;
        rs2     = src2;
        wb_data = wb;
        #30;
    endtask

    task automatic check_load(input string name, input logic [2:0] f3,
                              input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] expected;
        expected = load_value(model_mem[addr[10:3]], int'(addr[2:0]), f3);
        run_cycle(load_op(f3, 5'd10), addr, '0, '0);
        checks++;
        if (ls_res !== expected) begin
            errors++;
            $display("mismatch %s: expected %h actual %h", name, expected, ls_res);
        end
    endtask

    task automatic csr_access(input string name, input logic [2:0] f3, input logic [11:0] addr,
                              input logic [4:0] src, input logic [XLEN-1:0] operand,
                              input logic [XLEN-1:0] expected);
        run_cycle(csr_op(f3, addr, src), operand, '0, '0);
        checks += 2;
        if (csr_data !== expected) begin
            errors++;
            $display("mismatch %s: expected %h actual %h", name, expected, csr_data);
        end
        // register output still holds the value from before this cycle
        if (mtvec !== model_csr[0]) begin
            errors++;
            $display("mismatch %s mtvec_o: expected %h actual %h", name, model_csr[0], mtvec);
        end
    endtask

    task automatic wait_mtvec(input logic [XLEN-1:0] expected);
        int edges;
        edges = 0;
        while (mtvec !== expected && edges < 4) begin
            run_cycle(BUBBLE, '0, '0, '0);
            edges++;
        end
        checks++;
        if (mtvec !== expected) begin
            errors++;
            $display("mtvec_o did not reach %h within %0d clock edges", expected, edges);
        end else if (edges != 1) begin
            errors++;
            $display("mtvec_o took %0d clock edges to update instead of one", edges);
        end
    endtask

    task automatic reset_values();
        run_cycle(BUBBLE, '0, '0, '0);
        checks += 3;
        if (ls_res !== '0) begin
            errors++;
            $display("mismatch reset ls_res_o: expected %h actual %h", 64'h0, ls_res);
        end
        if (csr_data !== '0) begin
            errors++;
            $display("mismatch reset csr_data_o: expected %h actual %h", 64'h0, csr_data);
        end
        if (mtvec !== '0) begin
            errors++;
            $display("mismatch reset mtvec_o: expected %h actual %h", 64'h0, mtvec);
        end
    endtask

    task automatic dword_roundtrip();
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
        for (int i = 0; i < 8; i++) begin
            // upper address bits beyond the ram wrap around
            addr = take_bits(61) << 3;
            data = take_bits(64);
            run_cycle(store_op(mem_stage_pkg::F3_D, 5'd11), addr, data, '0);
            model_mem[addr[10:3]] = data;
            check_load("dword ld", mem_stage_pkg::F3_D, addr);
        end
    endtask

    task automatic lane_accesses();
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
        logic [2:0]      f3s;
        logic [2:0]      f3u;
        int              nbytes;
        int              flip;
        base = take_bits(61) << 3;
        flip = 0;
        run_cycle(store_op(mem_stage_pkg::F3_D, 5'd11), base, 64'h0123_4567_89ab_cdef, '0);
        model_mem[base[10:3]] = 64'h0123_4567_89ab_cdef;
        for (int sz = 0; sz < 3; sz++) begin
            nbytes = 1 << sz;
            // b, h, w codes are 0..2 and their unsigned forms sit 4 higher
            f3s = 3'(sz);
            f3u = 3'(sz + 4);
            for (int off = 0; off < 8; off += nbytes) begin
                addr = base + XLEN'(off);
                data = take_bits(64);
                data[8 * nbytes - 1] = flip[0];
                flip++;
                run_cycle(store_op(f3s, 5'd11), addr, data, '0);
                model_mem[base[10:3]] = merge_bytes(model_mem[base[10:3]], off, f3s, data);
                check_load($sformatf("lanes f3=%0d off=%0d", f3s, off), f3s, addr);
                check_load($sformatf("lanes f3=%0d off=%0d", f3u, off), f3u, addr);
                // other lanes untouched
                check_load("lanes ld", mem_stage_pkg::F3_D, base);
            end
        end
    endtask

    task automatic store_forwarding();
        logic [XLEN-1:0] addr_a;
        logic [XLEN-1:0] addr_b;
        logic [XLEN-1:0] reg_val;
        logic [XLEN-1:0] wb_val;
        addr_a  = take_bits(61) << 3;
        addr_b  = addr_a ^ 64'h8;
        reg_val = take_bits(64);
        run_cycle(store_op(mem_stage_pkg::F3_D, 5'd11), addr_a, reg_val, '0);
        model_mem[addr_a[10:3]] = reg_val;

        // load into x12 then a store of x12 takes the write-back value
        reg_val = take_bits(64);
        wb_val  = take_bits(64);
        run_cycle(load_op(mem_stage_pkg::F3_D, 5'd12), addr_a, '0, '0);
        run_cycle(store_op(mem_stage_pkg::F3_D, 5'd12), addr_b, reg_val, wb_val);
        model_mem[addr_b[10:3]] = wb_val;
        check_load("forward hit", mem_stage_pkg::F3_D, addr_b);

        // store of x13 after a load into x12 keeps rs2
        reg_val = take_bits(64);
        wb_val  = take_bits(64);
        run_cycle(load_op(mem_stage_pkg::F3_D, 5'd12), addr_a, '0, '0);
        run_cycle(store_op(mem_stage_pkg::F3_D, 5'd13), addr_b, reg_val, wb_val);
        model_mem[addr_b[10:3]] = reg_val;
        check_load("forward miss", mem_stage_pkg::F3_D, addr_b);
    endtask

    task automatic csr_sequence();
        logic [11:0]     addrs [3];
        logic [2:0]      f3;
        logic [4:0]      src;
        logic [XLEN-1:0] operand;
        logic [XLEN-1:0] old_val;
        logic [XLEN-1:0] new_val;
        addrs = '{mem_stage_pkg::CSR_MTVEC, mem_stage_pkg::CSR_MSCRATCH,
                  mem_stage_pkg::CSR_MEPC};
        for (int c = 0; c < 3; c++) begin
            // rw, rs, rc, then a set from x0 which only reads
            for (int k = 0; k < 4; k++) begin
                operand = take_bits(64);
                old_val = model_csr[c];
                src     = (k == 3) ? 5'd0 : 5'd3;
                if (k == 0) begin
                    f3      = mem_stage_pkg::F3_CSRRW;
                    new_val = operand;
                end else if (k == 2) begin
                    f3      = mem_stage_pkg::F3_CSRRC;
                    new_val = old_val & ~operand;
                end else begin
                    f3      = mem_stage_pkg::F3_CSRRS;
                    new_val = (src == 5'd0) ? old_val : (old_val | operand);
                end
                csr_access($sformatf("csr %h step %0d", addrs[c], k), f3, addrs[c], src,
                           operand, old_val);
                model_csr[c] = new_val;
                if (c == 0 && new_val != old_val) begin
                    wait_mtvec(new_val);
                end
            end
        end
        for (int c = 0; c < 3; c++) begin
            csr_access("csr readback", mem_stage_pkg::F3_CSRRS, addrs[c], 5'd0,
                       take_bits(64), model_csr[c]);
        end
        // mstatus is not implemented here
        csr_access("csr unknown rw", mem_stage_pkg::F3_CSRRW, 12'h300, 5'd3, take_bits(64), '0);
        csr_access("csr unknown rs", mem_stage_pkg::F3_CSRRS, 12'h300, 5'd0, '0, '0);
    endtask

    initial begin
        lfsr_q       = 32'd31;
        errors       = 0;
        checks       = 0;
        arst_n_i     = 1'b0;
        instr        = BUBBLE;
        alu_res      = '0;
        rs2          = '0;
        wb_data      = '0;
        model_csr[0] = '0;
        model_csr[1] = '0;
        model_csr[2] = '0;
        repeat (4) @(posedge clk);
        #2;
        arst_n_i = 1'b1;

        reset_values();
        dword_roundtrip();
        lane_accesses();
        store_forwarding();
        csr_sequence();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage #(
    parameter int RAM_DEPTH = 256
) (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic [31:0]                    instr_i,
    input  logic [mem_stage_pkg::XLEN-1:0] alu_res_i,
    input  logic [mem_stage_pkg::XLEN-1:0] rs2_i,
    input  logic [mem_stage_pkg::XLEN-1:0] wb_data_i,
    output logic [mem_stage_pkg::XLEN-1:0] ls_res_o,
    output logic [mem_stage_pkg::XLEN-1:0] csr_data_o,
    output logic [mem_stage_pkg::XLEN-1:0] mtvec_o
);

    logic                           load_en;
    logic                           store_en;
    logic                           csr_en;
    logic [2:0]                     size;
    logic [mem_stage_pkg::XLEN-1:0] store_data;
    logic [mem_stage_pkg::XLEN-1:0] ram_rdata;
    logic [mem_stage_pkg::XLEN-1:0] ram_wdata;

    mem_ctrl u_ctrl (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .instr_i      (instr_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .load_en_o    (load_en),
        .store_en_o   (store_en),
        .csr_en_o     (csr_en),
        .size_o       (size),
        .store_data_o (store_data)
    );

    data_ram #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_ram (
        .clk     (clk),
        .we_i    (store_en),
        .addr_i  (alu_res_i),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    // low address bits give the lane inside the doubleword
    load_align u_load (
        .rdata_i   (ram_rdata),
        .lane_i    (alu_res_i[2:0]),
        .size_i    (size),
        .load_en_i (load_en),
        .result_o  (ls_res_o)
    );

    store_merge u_merge (
        .rdata_i  (ram_rdata),
        .lane_i   (alu_res_i[2:0]),
        .size_i   (size),
        .wdata_i  (store_data),
        .merged_o (ram_wdata)
    );

    // alu result carries the rs1 value for csr instructions
    csr_unit u_csr (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .csr_en_i   (csr_en),
        .instr_i    (instr_i),
        .operand_i  (alu_res_i),
        .csr_data_o (csr_data_o),
        .mtvec_o    (mtvec_o)
    );

endmodule

// ==== verilog/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           csr_en_i,
    input  mem_stage_pkg::instr_u          instr_i,
    input  logic [mem_stage_pkg::XLEN-1:0] operand_i,
    output logic [mem_stage_pkg::XLEN-1:0] csr_data_o,
    output logic [mem_stage_pkg::XLEN-1:0] mtvec_o
);

    logic [mem_stage_pkg::XLEN-1:0] mtvec_q;
    logic [mem_stage_pkg::XLEN-1:0] mscratch_q;
    logic [mem_stage_pkg::XLEN-1:0] mepc_q;
    logic [mem_stage_pkg::XLEN-1:0] old_val;
    logic [mem_stage_pkg::XLEN-1:0] new_val;
    logic                           wr_en;

    // read side, unknown addresses give zero
    always_comb begin
        case (instr_i.itype.imm)
            mem_stage_pkg::CSR_MTVEC:    old_val = mtvec_q;
            mem_stage_pkg::CSR_MSCRATCH: old_val = mscratch_q;
            mem_stage_pkg::CSR_MEPC:     old_val = mepc_q;
            default:                     old_val = '0;
        endcase
    end

    always_comb begin
        case (instr_i.itype.funct3)
            mem_stage_pkg::F3_CSRRS: new_val = old_val | operand_i;
            mem_stage_pkg::F3_CSRRC: new_val = old_val & ~operand_i;
            default:                 new_val = operand_i;
        endcase
    end

    // set and clear with x0 as source only read
    assign wr_en = csr_en_i &&
                   ((instr_i.itype.funct3 == mem_stage_pkg::F3_CSRRW) ||
                    (instr_i.itype.rs1 != 5'd0));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
        end else if (wr_en) begin
            case (instr_i.itype.imm)
                mem_stage_pkg::CSR_MTVEC:    mtvec_q    <= new_val;
                mem_stage_pkg::CSR_MSCRATCH: mscratch_q <= new_val;
                mem_stage_pkg::CSR_MEPC:     mepc_q     <= new_val;
                default: begin
                end
            endcase
        end
    end

    // old value shows in the same cycle
    assign csr_data_o = csr_en_i ? old_val : '0;

    assign mtvec_o = mtvec_q;

endmodule

// ==== verilog/store_merge.sv ====
`timescale 1ns/1ps

module store_merge (
    input  logic [mem_stage_pkg::XLEN-1:0] rdata_i,
    input  logic [2:0]                     lane_i,
    input  logic [2:0]                     size_i,
    input  logic [mem_stage_pkg::XLEN-1:0] wdata_i,
    output logic [mem_stage_pkg::XLEN-1:0] merged_o
);

    logic [7:0]                     byte_en;
    logic [mem_stage_pkg::XLEN-1:0] wide;

    // replicate the store data across the doubleword and mark the lanes it owns
    always_comb begin
        byte_en = 8'h00;
        wide    = wdata_i;
        case (size_i)
            mem_stage_pkg::F3_B: begin
                byte_en = 8'h01 << lane_i;
                wide    = {8{wdata_i[7:0]}};
            end
            mem_stage_pkg::F3_H: begin
                byte_en = 8'h03 << {lane_i[2:1], 1'b0};
                wide    = {4{wdata_i[15:0]}};
            end
            mem_stage_pkg::F3_W: begin
                byte_en = 8'h0f << {lane_i[2], 2'b00};
                wide    = {2{wdata_i[31:0]}};
            end
            mem_stage_pkg::F3_D: begin
                byte_en = 8'hff;
                wide    = wdata_i;
            end
            default: begin
                byte_en = 8'h00;
            end
        endcase
    end

    // old bytes kept where the store does not reach
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            if (byte_en[i]) begin
                merged_o[8*i +: 8] = wide[8*i +: 8];
            end else begin
                merged_o[8*i +: 8] = rdata_i[8*i +: 8];
            end
        end
    end

endmodule

// ==== verilog/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  logic [mem_stage_pkg::XLEN-1:0] rdata_i,
    input  logic [2:0]                     lane_i,
    input  logic [2:0]                     size_i,
    input  logic                           load_en_i,
    output logic [mem_stage_pkg::XLEN-1:0] result_o
);

    logic [7:0]                     sel_b;
    logic [15:0]                    sel_h;
    logic [31:0]                    sel_w;
    logic [mem_stage_pkg::XLEN-1:0] ext;

    // pick the addressed lanes, accesses are assumed aligned
    always_comb begin
        sel_b = rdata_i[8*lane_i +: 8];
        sel_h = rdata_i[16*lane_i[2:1] +: 16];
        sel_w = rdata_i[32*lane_i[2] +: 32];
    end

    always_comb begin
        case (size_i)
            mem_stage_pkg::F3_B: begin
                ext = {{(mem_stage_pkg::XLEN-8){sel_b[7]}}, sel_b};
            end
            mem_stage_pkg::F3_BU: begin
                ext = {{(mem_stage_pkg::XLEN-8){1'b0}}, sel_b};
            end
            mem_stage_pkg::F3_H: begin
                ext = {{(mem_stage_pkg::XLEN-16){sel_h[15]}}, sel_h};
            end
            mem_stage_pkg::F3_HU: begin
                ext = {{(mem_stage_pkg::XLEN-16){1'b0}}, sel_h};
            end
            mem_stage_pkg::F3_W: begin
                ext = {{(mem_stage_pkg::XLEN-32){sel_w[31]}}, sel_w};
            end
            mem_stage_pkg::F3_WU: begin
                ext = {{(mem_stage_pkg::XLEN-32){1'b0}}, sel_w};
            end
            mem_stage_pkg::F3_D: begin
                ext = rdata_i;
            end
            default: begin
                ext = '0;
            end
        endcase
    end

    // nothing on the result bus without a load
    assign result_o = load_en_i ? ext : '0;

endmodule

// ==== verilog/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_DEPTH = 256
) (
    input  logic                           clk,
    input  logic                           we_i,
    input  logic [mem_stage_pkg::XLEN-1:0] addr_i,
    input  logic [mem_stage_pkg::XLEN-1:0] wdata_i,
    output logic [mem_stage_pkg::XLEN-1:0] rdata_o
);

    // index width, depth is a power of two so slicing wraps the address
    localparam int AW = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

    logic [mem_stage_pkg::XLEN-1:0] mem [RAM_DEPTH];
    logic [AW-1:0]                  idx;

    // doubleword index, byte offset bits dropped
    assign idx = addr_i[AW+2:3];

    // asynchronous read
    assign rdata_o = mem[idx];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[idx] <= wdata_i;
        end
    end

endmodule

// ==== verilog/mem_ctrl.sv ====
`timescale 1ns/1ps

module mem_ctrl (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  mem_stage_pkg::instr_u          instr_i,
    input  logic [mem_stage_pkg::XLEN-1:0] rs2_i,
    input  logic [mem_stage_pkg::XLEN-1:0] wb_data_i,
    output logic                           load_en_o,
    output logic                           store_en_o,
    output logic                           csr_en_o,
    output logic [2:0]                     size_o,
    output logic [mem_stage_pkg::XLEN-1:0] store_data_o
);

    logic       is_load;
    logic       is_store;
    logic       is_system;
    logic       prev_load_q;
    logic [4:0] prev_rd_q;
    logic       fwd_hit;

    assign is_load   = (instr_i.itype.opcode == mem_stage_pkg::OPC_LOAD);
    assign is_store  = (instr_i.stype.opcode == mem_stage_pkg::OPC_STORE);
    assign is_system = (instr_i.itype.opcode == mem_stage_pkg::OPC_SYSTEM);

    // funct3 sits at the same place in both views
    assign size_o = instr_i.itype.funct3;

    // funct3 of 7 is not a load size
    assign load_en_o  = is_load && (instr_i.itype.funct3 != 3'b111);
    // stores only exist for sizes b, h, w, d
    assign store_en_o = is_store && !instr_i.stype.funct3[2];

    // only the register csr forms are handled
    assign csr_en_o = is_system &&
                      ((instr_i.itype.funct3 == mem_stage_pkg::F3_CSRRW) ||
                       (instr_i.itype.funct3 == mem_stage_pkg::F3_CSRRS) ||
                       (instr_i.itype.funct3 == mem_stage_pkg::F3_CSRRC));

    // remember whether the last instruction was a load and where it went
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prev_load_q <= 1'b0;
        end else begin
            prev_load_q <= is_load;
        end
    end

    always_ff @(posedge clk) begin
        prev_rd_q <= instr_i.itype.rd;
    end

    // rs2 of this store is still being written back by the previous load
    assign fwd_hit = prev_load_q && (prev_rd_q == instr_i.stype.rs2);

    assign store_data_o = fwd_hit ? wb_data_i : rs2_i;

endmodule

// ==== verilog/mem_stage_pkg.sv ====
package mem_stage_pkg;

    // data path width for RV64
    localparam int XLEN = 64;

    // major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // access size codes, stores use only the first four
    localparam logic [2:0] F3_B  = 3'd0;
    localparam logic [2:0] F3_H  = 3'd1;
    localparam logic [2:0] F3_W  = 3'd2;
    localparam logic [2:0] F3_D  = 3'd3;
    localparam logic [2:0] F3_BU = 3'd4;
    localparam logic [2:0] F3_HU = 3'd5;
    localparam logic [2:0] F3_WU = 3'd6;

    // register forms of the csr instructions
    localparam logic [2:0] F3_CSRRW = 3'd1;
    localparam logic [2:0] F3_CSRRS = 3'd2;
    localparam logic [2:0] F3_CSRRC = 3'd3;

    // machine csr addresses
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;

    // loads and csrs are read as I-type, stores as S-type
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } itype;
        struct packed {
            logic [6:0]  imm_hi;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } stype;
    } instr_u;

endpackage
